// ==== src.f ====
+incdir+hdl
hdl/cachePkg.sv
hdl/wayArray.sv
hdl/tagStore.sv
hdl/dataStore.sv
hdl/plruReplacer.sv
hdl/cacheSequencer.sv
hdl/cacheController.sv
tb/tbClockGen.sv
tb/tbCacheController.sv

// ==== Bender.yml ====
package:
  name: cache_controller

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/cachePkg.sv
      - hdl/wayArray.sv
      - hdl/tagStore.sv
      - hdl/dataStore.sv
      - hdl/plruReplacer.sv
      - hdl/cacheSequencer.sv
      - hdl/cacheController.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - tb/tbClockGen.sv
      - tb/tbCacheController.sv

// ==== tb/tbCacheController.sv ====
/*
 * testbench of the four-way read cache
 * DRAM model, reference model of tags and pseudo-LRU bits,
 * directed and random bus cycles, assertion checks and watchdog
 */
`include "cache_macros.svh"

module tbCacheController;

	localparam int clockPeriod = 40;
	localparam int maxRequests = 614; // directed cycles plus worst case random reads and writes
	localparam int cyclesPerRequest = 200;

	logic Clock;
	logic Reset_L;
	cachePkg::cpuReqT cpuReq;
	cachePkg::cpuRspT cpuRsp;
	cachePkg::dramReqT dramReq;
	cachePkg::dramRspT dramRsp;

	integer seed = 32'ha2f2_23fd;
	int checkCount = 0;
	int errorCount = 0;
	logic selectSeen; // selectL fell in this bus cycle
	logic writeCycle; // current bus cycle is a write

	logic [`TAG_WIDTH-1:0] modelTag [`CACHE_SETS][`CACHE_WAYS];
	logic modelValid [`CACHE_SETS][`CACHE_WAYS];
	logic [2:0] modelTree [`CACHE_SETS]; // pseudo-LRU bits per set

	tbClockGen i_tbClockGen (.Clock (Clock), .Reset_L (Reset_L));

	cacheController i_cacheController (
		.Clock (Clock),
		.Reset_L (Reset_L),
		.cpuReq (cpuReq),
		.cpuRsp (cpuRsp),
		.dramReq (dramReq),
		.dramRsp (dramRsp)
	);

	////////////////////
	// reference model
	function automatic int findWay(input logic [31:0] addr);
		int way;
		way = -1; // miss
		for (int w = 0; w < `CACHE_WAYS; w++) begin
			if (modelValid[addr[6:4]][w] && modelTag[addr[6:4]][w] == addr[31:7]) begin
				way = w;
			end
		end
		return way;
	endfunction

	function automatic int pickVictim(input logic [2:0] tree);
		if (!tree[0]) begin
			return tree[1] ? 1 : 0; // pair of ways 0 and 1
		end
		return tree[2] ? 3 : 2;
	endfunction

	function automatic logic [2:0] pointAway(input logic [2:0] tree, input int way);
		logic [2:0] updated;
		updated = tree;
		case (way)
			0: updated[1:0] = 2'b11;
			1: updated[1:0] = 2'b01;
			2: updated = {1'b1, tree[1], 1'b0}; // bit 1 kept
			default: updated = {1'b0, tree[1], 1'b0};
		endcase
		return updated;
	endfunction

	////////////////////
	// checks and bus cycles
	task automatic checkValue(input string name, input logic [31:0] got, input logic [31:0] exp);
		checkCount++;
		assert (got === exp) else begin
			errorCount++;
			$display("CHECK FAILED: %s got %h expected %h", name, got, exp);
		end
	endtask

	task automatic waitDtack();
		do begin
			@(posedge Clock); // outputs settled, state not yet updated
		end while (cpuRsp.dtackL);
	endtask

	task automatic readWord(input logic [31:0] addr);
		int set;
		int way;
		logic [15:0] expData;
		set = addr[6:4];
		way = findWay(addr);
		expData = {addr[15:4], 1'b0, addr[3:1]}; // line bits high, word number low
		@(negedge Clock);
		selectSeen = 1'b0;
		writeCycle = 1'b0;
		cpuReq = '{asL: 1'b0, udsL: 1'b0, ldsL: 1'b0, weL: 1'b1, dramSelect: 1'b1,
			address: addr, writeData: '0};
		waitDtack();
		checkValue("cpuRsp.readData", cpuRsp.readData, expData);
		@(negedge Clock);
		cpuReq.asL = 1'b1; // end of bus cycle
		cpuReq.dramSelect = 1'b0;
		checkValue("dramReq.selectL fell", selectSeen, way < 0);
		if (way < 0) begin
			way = pickVictim(modelTree[set]);
			modelTag[set][way] = addr[31:7];
			modelValid[set][way] = 1'b1;
		end
		modelTree[set] = pointAway(modelTree[set], way);
	endtask

	task automatic writeWord(input logic [31:0] addr, input logic [15:0] data,
		input logic [1:0] strobes);
		int set;
		set = addr[6:4];
		@(negedge Clock);
		selectSeen = 1'b0;
		writeCycle = 1'b1;
		cpuReq = '{asL: 1'b0, udsL: strobes[1], ldsL: strobes[0], weL: 1'b0, dramSelect: 1'b1,
			address: addr, writeData: data};
		waitDtack();
		@(negedge Clock);
		cpuReq.asL = 1'b1;
		cpuReq.weL = 1'b1;
		cpuReq.dramSelect = 1'b0;
		checkValue("dramReq.selectL fell", selectSeen, 1'b1);
		for (int w = 0; w < `CACHE_WAYS; w++) begin
			if (modelValid[set][w] && modelTag[set][w] == addr[31:7]) begin
				modelValid[set][w] = 1'b0; // write-through drops the line
			end
		end
	endtask

	task automatic reportTest(input int num, input string name, input int errorsBefore);
		$display("test %0d %s: %0d checks failed", num, name, errorCount - errorsBefore);
	endtask

	// DRAM side of every bus cycle, sampled where inputs are stable
	always @(posedge Clock) begin
		if (Reset_L && !dramReq.selectL) begin
			selectSeen = 1'b1;
			if (writeCycle) begin
				checkValue("dramReq.address", dramReq.address, cpuReq.address);
				checkValue("dramReq.writeData", dramReq.writeData, cpuReq.writeData);
				checkValue("dramReq.asL udsL ldsL weL",
					{dramReq.asL, dramReq.udsL, dramReq.ldsL, dramReq.weL},
					{cpuReq.asL, cpuReq.udsL, cpuReq.ldsL, cpuReq.weL});
				checkValue("cpuRsp.dtackL", cpuRsp.dtackL, dramRsp.dtackL);
			end else begin
				checkValue("dramReq.address", dramReq.address, {cpuReq.address[31:4], 4'h0});
			end
		end
	end

	////////////////////
	// DRAM model
	initial begin : dramModel
		int delay;
		logic [31:0] lineAddr;
		dramRsp = '{dtackL: 1'b1, casL: 1'b1, rasL: 1'b1, readData: '0};
		forever begin
			@(negedge Clock);
			if (Reset_L && !dramReq.selectL) begin
				if (!dramReq.weL) begin
					repeat (2) @(negedge Clock);
					dramRsp.dtackL = 1'b0; // write done
				end else begin
					lineAddr = dramReq.address;
					delay = 1 + {$random(seed)} % 4;
					repeat (delay) @(negedge Clock);
					if ({$random(seed)} % 4 == 0) begin
						dramRsp.casL = 1'b0; // refresh, both strobes low
						dramRsp.rasL = 1'b0;
						@(negedge Clock);
						dramRsp.casL = 1'b1;
						dramRsp.rasL = 1'b1;
						@(negedge Clock);
					end
					dramRsp.casL = 1'b0; // start of data
					@(negedge Clock);
					dramRsp.casL = 1'b1;
					repeat (2) @(negedge Clock);
					for (int w = 0; w < `LINE_WORDS; w++) begin
						dramRsp.readData = {lineAddr[15:4], 4'(w)};
						@(negedge Clock);
					end
				end
				while (!dramReq.selectL) begin
					@(negedge Clock);
				end
				dramRsp.dtackL = 1'b1;
			end
		end
	end

	////////////////////
	// stimulus
	initial begin : stimulus
		int errorsBefore;
		int tagPick;
		int setPick;
		int wordPick;
		logic [31:0] addr;
		cpuReq = '{asL: 1'b1, udsL: 1'b1, ldsL: 1'b1, weL: 1'b1, dramSelect: 1'b0,
			address: '0, writeData: '0};
		selectSeen = 1'b0;
		writeCycle = 1'b0;
		for (int s = 0; s < `CACHE_SETS; s++) begin
			modelTree[s] = '0;
			for (int w = 0; w < `CACHE_WAYS; w++) begin
				modelValid[s][w] = 1'b0;
				modelTag[s][w] = '0;
			end
		end
		@(posedge Reset_L);
		@(posedge Clock);
		checkValue("cpuRsp.dtackL", cpuRsp.dtackL, 1'b1);
		checkValue("dramReq.selectL", dramReq.selectL, 1'b1);

		errorsBefore = errorCount;
		readWord(32'h0001_2346); // set 4, word 3
		reportTest(1, "cold read miss", errorsBefore);

		errorsBefore = errorCount;
		readWord(32'h0001_234c);
		reportTest(2, "read hit", errorsBefore);

		errorsBefore = errorCount;
		writeWord(32'h0001_2348, 16'hbeef, 2'b00);
		readWord(32'h0001_2340); // line was dropped
		reportTest(3, "write-through", errorsBefore);

		errorsBefore = errorCount;
		for (int pass = 0; pass < 2; pass++) begin
			for (int i = 0; i < 5; i++) begin
				readWord({25'h300 + 25'(i), 3'd5, 4'h2}); // five tags, one set
			end
		end
		reportTest(4, "pseudo-LRU replacement", errorsBefore);

		errorsBefore = errorCount;
		for (int n = 0; n < 300; n++) begin
			tagPick = {$random(seed)} % 6;
			setPick = {$random(seed)} % 4;
			wordPick = {$random(seed)} % 8;
			addr = {25'h40 + 25'(tagPick), 3'(setPick), 3'(wordPick), 1'b0};
			if ({$random(seed)} % 6 == 0) begin
				writeWord(addr ^ 32'h2, 16'($random(seed)), 2'({$random(seed)} % 3));
			end
			readWord(addr);
		end
		reportTest(5, "random reads", errorsBefore);

		$display("tests: 5, checks: %0d, errors: %0d", checkCount, errorCount);
		if (errorCount == 0) begin
			$display("PASS: all tests");
		end else begin
			$display("FAIL: see errors above");
		end
		$finish;
	end

	initial begin : watchdog
		#(maxRequests * cyclesPerRequest * clockPeriod);
		$display("timeout: run did not finish within %0d cycles", maxRequests * cyclesPerRequest);
		$display("FAIL: see errors above");
		$finish;
	end

endmodule

// ==== tb/tbClockGen.sv ====
/*
 * testbench clock and reset
 * 40 unit clock, reset low for the first two cycles
 */

module tbClockGen (
	output logic Clock,
	output logic Reset_L
);

	localparam int clockPeriod = 40;

	initial begin
		Clock = 1'b0;
		Reset_L = 1'b0;
		#(2 * clockPeriod) Reset_L = 1'b1; // released on a falling edge
	end

	always #(clockPeriod / 2) Clock = ~Clock;

endmodule

// ==== hdl/cacheController.sv ====
/*
 * four-way read cache between a 68000 bus and a DRAM controller
 * sequencer, tag store, data store and pseudo-LRU replacer
 */
`include "cache_macros.svh"

module cacheController (
	input logic Clock,
	input logic Reset_L,
	input cachePkg::cpuReqT cpuReq,
	output cachePkg::cpuRspT cpuRsp,
	output cachePkg::dramReqT dramReq,
	input cachePkg::dramRspT dramRsp
);

	cachePkg::cacheCtlT cacheCtl; // sequencer command to both stores
	cachePkg::wayMaskT hitWays; // valid and tag match per way
	cachePkg::wayNumT victimWay; // replacer choice for current set
	cachePkg::wayNumT accessWay; // way used by this lookup
	logic lruUpdate;
	logic lruClear;
	logic dtackL;
	logic [`DATA_WIDTH-1:0] readData;
	logic [`TAG_WIDTH-1:0] lookupTag;

	assign lookupTag = cpuReq.address[`ADDR_WIDTH-1 -: `TAG_WIDTH]; // tag bits of CPU address
	assign cpuRsp = '{readData: readData, dtackL: dtackL};

	////////////////////
	// control
	cacheSequencer i_cacheSequencer (
		.Clock (Clock),
		.Reset_L (Reset_L),
		.cpuReq (cpuReq),
		.dtackL (dtackL),
		.dramReq (dramReq),
		.dramRsp (dramRsp),
		.hitWays (hitWays),
		.victimWay (victimWay),
		.lruUpdate (lruUpdate),
		.lruClear (lruClear),
		.accessWay (accessWay),
		.cacheCtl (cacheCtl)
	);

	plruReplacer i_plruReplacer (
		.Clock (Clock),
		.Reset_L (Reset_L),
		.index (cacheCtl.index), // same set the stores look at
		.update (lruUpdate),
		.clear (lruClear),
		.accessWay (accessWay),
		.victimWay (victimWay)
	);

	////////////////////
	// storage
	tagStore i_tagStore (
		.Clock (Clock),
		.cacheCtl (cacheCtl),
		.lookupTag (lookupTag),
		.hitWays (hitWays)
	);

	dataStore i_dataStore (
		.Clock (Clock),
		.cacheCtl (cacheCtl),
		.fillData (dramRsp.readData), // burst words straight from DRAM
		.hitWays (hitWays),
		.readData (readData)
	);

endmodule

// ==== hdl/cacheSequencer.sv ====
/*
 * cache sequencer FSM
 * invalidate sweep after reset, hit and miss handling, burst fill,
 * write-through with hit invalidation, burst counter and victim register
 */
`include "cache_macros.svh"

module cacheSequencer (
	input logic Clock,
	input logic Reset_L,
	input cachePkg::cpuReqT cpuReq,
	output logic dtackL,
	output cachePkg::dramReqT dramReq,
	input cachePkg::dramRspT dramRsp,
	input cachePkg::wayMaskT hitWays,
	input cachePkg::wayNumT victimWay,
	output logic lruUpdate,
	output logic lruClear,
	output cachePkg::wayNumT accessWay,
	output cachePkg::cacheCtlT cacheCtl
);

	typedef enum logic [3:0] {
		Reset,
		InvalidateCache, // clear one set per cycle
		Idle,
		CheckForCacheHit,
		WaitForEndOfCacheRead,
		ReadDataFromDramIntoCache, // wait for CAS, victim tag written here
		CASDelay1,
		CASDelay2,
		BurstFill,
		EndBurstFill,
		WriteDataToDram
	} stateT;

	localparam logic [`BURST_COUNT_WIDTH-1:0] setsDone = `CACHE_SETS; // sweep finished
	localparam logic [`BURST_COUNT_WIDTH-1:0] lastWord = `LINE_WORDS - 1;

	stateT state;
	stateT nextState;
	logic [`BURST_COUNT_WIDTH-1:0] burstCount;
	logic countClear; // synchronous clear of burstCount
	cachePkg::wayNumT victimReg; // way being refilled
	logic loadVictim;
	cachePkg::wayMaskT victimMask;
	cachePkg::wayNumT hitWay; // encoded hitWays
	logic busEnd; // CPU has closed its cycle
	logic [`TAG_WIDTH-1:0] cpuTag;
	logic [`INDEX_WIDTH-1:0] cpuIndex;
	logic [`WORD_SEL_WIDTH-1:0] cpuWord;

	assign cpuTag = cpuReq.address[`ADDR_WIDTH-1 -: `TAG_WIDTH];
	assign cpuIndex = cpuReq.address[`WORD_SEL_WIDTH+1 +: `INDEX_WIDTH]; // bits 6..4
	assign cpuWord = cpuReq.address[1 +: `WORD_SEL_WIDTH]; // bits 3..1, bit 0 is byte
	assign victimMask = cachePkg::wayMaskT'(1) << victimReg;
	assign busEnd = cpuReq.asL || !cpuReq.dramSelect;

	always_comb begin
		hitWay = '0;
		for (int w = 0; w < `CACHE_WAYS; w++) begin
			if (hitWays[w]) begin
				hitWay = cachePkg::wayNumT'(w); // at most one way hits
			end
		end
	end

	////////////////////
	// state, counter and victim
	always_ff @(posedge Clock or negedge Reset_L) begin
		if (!Reset_L) begin
			state <= Reset;
			burstCount <= '0;
			victimReg <= '0;
		end else begin
			state <= nextState;
			burstCount <= countClear ? '0 : burstCount + 1'b1; // free running otherwise
			if (loadVictim) begin
				victimReg <= victimWay; // hold the choice for the whole fill
			end
		end
	end

	////////////////////
	// next state and outputs
	always_comb begin
		nextState = state;
		dtackL = 1'b1;
		dramReq.selectL = 1'b1; // no DRAM cycle unless asked for
		dramReq.asL = cpuReq.asL;
		dramReq.udsL = cpuReq.udsL;
		dramReq.ldsL = cpuReq.ldsL;
		dramReq.weL = cpuReq.weL;
		dramReq.address = {cpuReq.address[`ADDR_WIDTH-1:4], 4'b0000}; // line aligned
		dramReq.writeData = cpuReq.writeData;
		cacheCtl.index = cpuIndex;
		cacheCtl.wordSel = cpuWord;
		cacheCtl.tagWe = '0;
		cacheCtl.dataWe = '0;
		cacheCtl.validIn = 1'b0;
		cacheCtl.tagIn = cpuTag;
		lruUpdate = 1'b0;
		lruClear = 1'b0;
		accessWay = hitWay;
		countClear = 1'b0;
		loadVictim = 1'b0;

		case (state)
			Reset: begin
				countClear = 1'b1;
				nextState = InvalidateCache;
			end
			InvalidateCache: begin
				if (burstCount == setsDone) begin
					nextState = Idle;
				end else begin
					cacheCtl.index = burstCount[`INDEX_WIDTH-1:0]; // sweep sets
					cacheCtl.tagWe = '1; // all ways at once
					cacheCtl.tagIn = '0;
					lruClear = 1'b1;
				end
			end
			Idle: begin
				if (!cpuReq.asL && cpuReq.dramSelect) begin
					if (cpuReq.weL) begin
						nextState = CheckForCacheHit;
					end else begin
						cacheCtl.tagWe = hitWays; // drop any stale copy of the line
						nextState = WriteDataToDram;
					end
				end
			end
			CheckForCacheHit: begin
				dramReq.udsL = 1'b0;
				dramReq.ldsL = 1'b0;
				lruUpdate = 1'b1;
				if (|hitWays) begin
					dtackL = 1'b0; // data straight from the cache
					nextState = WaitForEndOfCacheRead;
				end else begin
					dramReq.selectL = 1'b0; // start the burst read
					accessWay = victimWay;
					loadVictim = 1'b1;
					nextState = ReadDataFromDramIntoCache;
				end
			end
			WaitForEndOfCacheRead: begin
				dramReq.udsL = 1'b0;
				dramReq.ldsL = 1'b0;
				dtackL = 1'b0;
				if (cpuReq.asL) begin
					nextState = Idle;
				end
			end
			ReadDataFromDramIntoCache: begin
				dramReq.udsL = 1'b0;
				dramReq.ldsL = 1'b0;
				dramReq.selectL = 1'b0;
				cacheCtl.tagWe = victimMask;
				cacheCtl.validIn = 1'b1;
				if (!dramRsp.casL && dramRsp.rasL) begin // refresh has rasL low too
					nextState = CASDelay1;
				end
			end
			CASDelay1: begin
				dramReq.udsL = 1'b0;
				dramReq.ldsL = 1'b0;
				dramReq.selectL = 1'b0;
				nextState = CASDelay2;
			end
			CASDelay2: begin
				dramReq.udsL = 1'b0;
				dramReq.ldsL = 1'b0;
				dramReq.selectL = 1'b0;
				countClear = 1'b1; // word 0 arrives next cycle
				nextState = BurstFill;
			end
			BurstFill: begin
				dramReq.udsL = 1'b0;
				dramReq.ldsL = 1'b0;
				dramReq.selectL = 1'b0;
				cacheCtl.wordSel = burstCount[`WORD_SEL_WIDTH-1:0];
				cacheCtl.dataWe = victimMask;
				if (burstCount == lastWord) begin
					nextState = EndBurstFill;
				end
			end
			EndBurstFill: begin
				dramReq.udsL = 1'b0;
				dramReq.ldsL = 1'b0;
				dtackL = 1'b0; // filled way now hits, word from CPU address
				if (busEnd) begin
					nextState = Idle;
				end
			end
			WriteDataToDram: begin
				dramReq.address = cpuReq.address; // full address for writes
				dramReq.selectL = 1'b0;
				dtackL = dramRsp.dtackL;
				if (busEnd) begin
					nextState = Idle;
				end
			end
			default: begin
				nextState = Reset;
			end
		endcase
	end

endmodule

// ==== hdl/plruReplacer.sv ====
/*
 * pseudo-LRU replacer
 * three tree bits per set, victim select and update on access
 */
`include "cache_macros.svh"

module plruReplacer (
	input logic Clock,
	input logic Reset_L,
	input logic [`INDEX_WIDTH-1:0] index,
	input logic update,
	input logic clear,
	input cachePkg::wayNumT accessWay,
	output cachePkg::wayNumT victimWay
);

	cachePkg::plruT treeBits [`CACHE_SETS]; // per set
	cachePkg::plruT curBits;
	cachePkg::plruT nextBits;

	assign curBits = treeBits[index];

	// bit 0 picks the pair, bit 1 or bit 2 the way inside it
	always_comb begin
		if (!curBits[0]) begin
			victimWay = curBits[1] ? cachePkg::wayNumT'(1) : cachePkg::wayNumT'(0);
		end else begin
			victimWay = curBits[2] ? cachePkg::wayNumT'(3) : cachePkg::wayNumT'(2);
		end
	end

	// steer the tree away from the way just used
	always_comb begin
		nextBits = curBits; // untouched bit kept
		case (accessWay)
			2'd0: begin
				nextBits[1:0] = 2'b11;
			end
			2'd1: begin
				nextBits[1:0] = 2'b01;
			end
			2'd2: begin
				nextBits[2] = 1'b1;
				nextBits[0] = 1'b0;
			end
			default: begin
				nextBits[2] = 1'b0;
				nextBits[0] = 1'b0;
			end
		endcase
	end

	always_ff @(posedge Clock or negedge Reset_L) begin
		if (!Reset_L) begin
			for (int s = 0; s < `CACHE_SETS; s++) begin
				treeBits[s] <= '0;
			end
		end else if (clear) begin
			treeBits[index] <= '0; // invalidate sweep
		end else if (update) begin
			treeBits[index] <= nextBits;
		end
	end

endmodule

// ==== hdl/dataStore.sv ====
/*
 * data store of the four ways
 * burst fill write per way and word select of the hitting way
 */
`include "cache_macros.svh"

module dataStore (
	input logic Clock,
	input cachePkg::cacheCtlT cacheCtl,
	input logic [`DATA_WIDTH-1:0] fillData,
	input cachePkg::wayMaskT hitWays,
	output logic [`DATA_WIDTH-1:0] readData
);

	logic [`INDEX_WIDTH+`WORD_SEL_WIDTH-1:0] wordAddr; // set and word
	logic [`DATA_WIDTH-1:0] wayWord [`CACHE_WAYS];

	assign wordAddr = {cacheCtl.index, cacheCtl.wordSel};

	for (genvar w = 0; w < `CACHE_WAYS; w++) begin : wayGen
		wayArray #(
			.entryT (logic [`DATA_WIDTH-1:0]),
			.depth (`CACHE_SETS * `LINE_WORDS)
		) i_dataWay (
			.Clock (Clock),
			.we (cacheCtl.dataWe[w]),
			.addr (wordAddr),
			.wrData (fillData),
			.rdData (wayWord[w])
		);
	end

	// hit vector is one-hot or empty, so an and-or mux does
	always_comb begin
		readData = '0;
		for (int w = 0; w < `CACHE_WAYS; w++) begin
			if (hitWays[w]) begin
				readData |= wayWord[w];
			end
		end
	end

endmodule

// ==== hdl/tagStore.sv ====
/*
 * tag and valid store of the four ways
 * per-way write and the combinational hit compare
 */
`include "cache_macros.svh"

module tagStore (
	input logic Clock,
	input cachePkg::cacheCtlT cacheCtl,
	input logic [`TAG_WIDTH-1:0] lookupTag,
	output cachePkg::wayMaskT hitWays
);

	cachePkg::tagEntryT wrEntry; // common to all ways, tagWe picks
	cachePkg::tagEntryT rdEntry [`CACHE_WAYS];

	assign wrEntry = '{valid: cacheCtl.validIn, tag: cacheCtl.tagIn};

	for (genvar w = 0; w < `CACHE_WAYS; w++) begin : wayGen
		wayArray #(
			.entryT (cachePkg::tagEntryT),
			.depth (`CACHE_SETS)
		) i_tagWay (
			.Clock (Clock),
			.we (cacheCtl.tagWe[w]),
			.addr (cacheCtl.index),
			.wrData (wrEntry),
			.rdData (rdEntry[w])
		);

		// hit needs a valid line with matching tag
		assign hitWays[w] = rdEntry[w].valid && (rdEntry[w].tag == lookupTag);
	end

endmodule

// ==== hdl/wayArray.sv ====
/*
 * one cache way as a register file
 * payload type set by parameter, synchronous write, asynchronous read
 */

module wayArray #(
	parameter type entryT = logic [15:0],
	parameter int depth = 8
) (
	input logic Clock,
	input logic we,
	input logic [$clog2(depth)-1:0] addr,
	input entryT wrData,
	output entryT rdData
);

	entryT mem [depth]; // contents, cleared only by the invalidate sweep

	always_ff @(posedge Clock) begin
		if (we) begin
			mem[addr] <= wrData;
		end
	end

	assign rdData = mem[addr]; // same address for read and write

endmodule

// ==== hdl/cachePkg.sv ====
/*
 * shared types of the cache
 * CPU and DRAM bus structs, way mask and way number,
 * pseudo-LRU tree bits, tag entry and the store command
 */
`include "cache_macros.svh"

package cachePkg;

	typedef struct packed {
		logic asL; // address strobe
		logic udsL; // upper byte strobe
		logic ldsL; // lower byte strobe
		logic weL; // low for write
		logic dramSelect; // address decodes to DRAM, active high
		logic [`ADDR_WIDTH-1:0] address;
		logic [`DATA_WIDTH-1:0] writeData;
	} cpuReqT;

	typedef struct packed {
		logic [`DATA_WIDTH-1:0] readData;
		logic dtackL;
	} cpuRspT;

	typedef struct packed {
		logic selectL; // cache selects the DRAM controller
		logic asL;
		logic udsL;
		logic ldsL;
		logic weL;
		logic [`ADDR_WIDTH-1:0] address;
		logic [`DATA_WIDTH-1:0] writeData; // write-through data
	} dramReqT;

	typedef struct packed {
		logic dtackL; // end of a write
		logic casL; // start of read data when rasL is high
		logic rasL; // low together with casL means refresh
		logic [`DATA_WIDTH-1:0] readData;
	} dramRspT;

	typedef logic [`CACHE_WAYS-1:0] wayMaskT; // one bit per way
	typedef logic [$clog2(`CACHE_WAYS)-1:0] wayNumT;
	typedef logic [`CACHE_WAYS-2:0] plruT; // tree bits of one set

	typedef struct packed {
		logic valid;
		logic [`TAG_WIDTH-1:0] tag;
	} tagEntryT;

	typedef struct packed {
		logic [`INDEX_WIDTH-1:0] index; // set being read or written
		logic [`WORD_SEL_WIDTH-1:0] wordSel; // word within the line
		wayMaskT tagWe; // tag and valid write per way
		wayMaskT dataWe; // fill write per way
		logic validIn;
		logic [`TAG_WIDTH-1:0] tagIn;
	} cacheCtlT;

endpackage

// ==== hdl/cache_macros.svh ====
/*
 * cache geometry macros
 * way and set counts, line size, bus widths, address split, burst counter width
 */
`ifndef CACHE_MACROS_SVH
`define CACHE_MACROS_SVH

// cache organisation
`define CACHE_WAYS 4 // four-way set associative
`define CACHE_SETS 8
`define LINE_WORDS 8 // 16-bit words per line

// 68000 side bus widths
`define ADDR_WIDTH 32
`define DATA_WIDTH 16

// address split: tag 31..7, index 6..4, word 3..1, byte 0
`define TAG_WIDTH 25
`define INDEX_WIDTH 3
`define WORD_SEL_WIDTH 3

// sweeps sets on invalidate and words on fill
`define BURST_COUNT_WIDTH 4

`endif
